/* logic/ldpc_enc_pkg.sv */
// --------------------
// shared constants of the first parity stage
// matrix size, circulant encoding, register map
// --------------------
package ldpc_enc_pkg;

  // code geometry
  localparam int pZC      = 8;              // bits per word, expansion factor
  localparam int pROWS    = 4;              // inverse psi is pROWS x pROWS circulants
  localparam int pSHIFT_W = $clog2(pZC);    // rotation amount width

  // --------------------
  // circulant table entry
  // --------------------
  // top bit set -> all zero block, low bits -> right rotation of identity
  typedef logic [pSHIFT_W:0] circ_t;

  localparam circ_t circ_zero = {1'b1, {pSHIFT_W{1'b0}}};  // zero block
  localparam circ_t circ_eye  = '0;                        // unrotated identity

  // --------------------
  // wishbone register map
  // --------------------
  localparam int pWB_ADR_W = 5;
  localparam int pWB_DAT_W = 8;

  // table entry (r, c) at word r*pROWS + c, control word right above
  localparam int pREG_CTRL       = pROWS * pROWS;
  localparam int ctrl_bypass_bit = 0;       // control bit 0 -> bypass multiply

  // counter width for an index over n items, never zero
  function automatic int idx_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

/* logic/ldpc_enc_wb_regs.sv */
// --------------------
// wishbone classic slave, circulant shift table and bypass flag
// --------------------
`timescale 1ns/1ps

module ldpc_enc_wb_regs #(
  parameter int pROWS = ldpc_enc_pkg::pROWS
) (
  input  logic                                   iclk     ,
  input  logic                                   ireset   ,
  input  logic                                   iclkena  ,
  //
  input  logic                                   wb_cyc   ,
  input  logic                                   wb_stb   ,
  input  logic                                   wb_we    ,
  input  logic [ldpc_enc_pkg::pWB_ADR_W-1:0]     wb_adr   ,
  input  logic [ldpc_enc_pkg::pWB_DAT_W-1:0]     wb_dat_w ,
  input  logic                                   wb_sel   ,
  output logic [ldpc_enc_pkg::pWB_DAT_W-1:0]     wb_dat_r ,
  output logic                                   wb_ack   ,
  //
  output ldpc_enc_pkg::circ_t [pROWS*pROWS-1:0]  inv_psi  ,  // entry r*pROWS+c
  output logic                                   bypass
);

  localparam int tbl_n = pROWS * pROWS;
  localparam int tw    = ldpc_enc_pkg::idx_w(tbl_n);
  localparam int sw    = ldpc_enc_pkg::pSHIFT_W;
  localparam int bb    = ldpc_enc_pkg::ctrl_bypass_bit;
  localparam logic [ldpc_enc_pkg::pWB_ADR_W-1:0] ctrl_adr =
    ldpc_enc_pkg::pREG_CTRL[ldpc_enc_pkg::pWB_ADR_W-1:0];

  logic          req;       // request seen, not yet acked
  logic          tbl_hit;
  logic          ctrl_hit;
  logic [tw-1:0] tbl_idx;

  assign req      = wb_cyc & wb_stb & ~wb_ack;   // ack lasts a single cycle
  assign tbl_hit  = (wb_adr < ctrl_adr);
  assign ctrl_hit = (wb_adr == ctrl_adr);        // above ctrl -> acked, ignored
  assign tbl_idx  = wb_adr[tw-1:0];

  // --------------------
  // ack and register writes
  // --------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wb_ack <= 1'b0;
      bypass <= 1'b0;
      for (int i = 0; i < tbl_n; i++) begin
        // diagonal -> identity, rest -> zero blocks
        inv_psi[i] <= ((i % (pROWS + 1)) == 0) ? ldpc_enc_pkg::circ_eye
                                                : ldpc_enc_pkg::circ_zero;
      end
    end
    else if (iclkena) begin
      wb_ack <= req;
      if (req && wb_we && wb_sel) begin
        if (tbl_hit) begin
          inv_psi[tbl_idx] <= wb_dat_w[sw:0];
        end
        else if (ctrl_hit) begin
          bypass <= wb_dat_w[bb];
        end
      end
    end
  end

  // read data valid together with ack
  always_ff @(posedge iclk) begin
    if (iclkena && req) begin
      wb_dat_r <= '0;                            // unmapped -> zero
      if (tbl_hit) begin
        wb_dat_r[sw:0] <= inv_psi[tbl_idx];
      end
      else if (ctrl_hit) begin
        wb_dat_r[bb] <= bypass;
      end
    end
  end

endmodule

/* logic/ldpc_enc_col_feed.sv */
// --------------------
// two bank block store, broadcasts one column word per cycle
// --------------------
`timescale 1ns/1ps

module ldpc_enc_col_feed #(
  parameter int pZC   = ldpc_enc_pkg::pZC   ,
  parameter int pROWS = ldpc_enc_pkg::pROWS
) (
  input  logic                                     iclk     ,
  input  logic                                     ireset   ,
  input  logic                                     iclkena  ,
  //
  input  logic                                     iwrite   ,
  input  logic                                     iwstart  ,  // restarts write counter
  input  logic [pZC-1:0]                           iwdat    ,
  //
  output logic                                     col_val  ,
  output logic                                     col_last ,
  output logic [ldpc_enc_pkg::idx_w(pROWS)-1:0]    col_idx  ,
  output logic [pZC-1:0]                           col_dat
);

  localparam int iw = ldpc_enc_pkg::idx_w(pROWS);
  localparam logic [iw-1:0] last_idx = iw'(pROWS - 1);

  logic [pZC-1:0] mem [2][pROWS];   // bank x word
  logic           wr_bank;
  logic           rd_bank;
  logic           rd_act;           // broadcast running
  logic [iw-1:0]  wr_cnt;
  logic [iw-1:0]  rd_cnt;
  logic [iw-1:0]  widx;
  logic           blk_done;
  logic           rd_last;

  assign widx     = iwstart ? '0 : wr_cnt;
  assign blk_done = iwrite && (widx == last_idx);   // last word of block
  assign rd_last  = rd_act && (rd_cnt == last_idx);

  always_ff @(posedge iclk) begin
    if (iclkena && iwrite) begin
      mem[wr_bank][widx] <= iwdat;
    end
  end

  // --------------------
  // write side and bank swap
  // --------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      wr_bank  <= 1'b0;
      wr_cnt   <= '0;
      rd_bank  <= 1'b0;
      rd_act   <= 1'b0;
      rd_cnt   <= '0;
      col_val  <= 1'b0;
      col_last <= 1'b0;
    end
    else if (iclkena) begin
      if (iwrite) begin
        wr_cnt <= blk_done ? '0 : widx + 1'b1;
      end
      if (blk_done) begin
        wr_bank <= ~wr_bank;          // next block into the free bank
        rd_bank <= wr_bank;           // broadcast the one just filled
        rd_act  <= 1'b1;
        rd_cnt  <= '0;
      end
      else if (rd_act) begin
        rd_cnt <= rd_last ? '0 : rd_cnt + 1'b1;
        rd_act <= ~rd_last;
      end
      col_val  <= rd_act;
      col_last <= rd_last;
    end
  end

  // column word to all lanes
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      col_idx <= rd_cnt;
      col_dat <= mem[rd_bank][rd_cnt];
    end
  end

endmodule

/* logic/ldpc_enc_row_acc.sv */
// --------------------
// one matrix row lane, rotate by circulant and xor accumulate
// --------------------
`timescale 1ns/1ps

module ldpc_enc_row_acc #(
  parameter int pZC   = ldpc_enc_pkg::pZC   ,
  parameter int pROWS = ldpc_enc_pkg::pROWS
) (
  input  logic                                     iclk     ,
  input  logic                                     ireset   ,
  input  logic                                     iclkena  ,
  //
  input  logic                                     col_val  ,
  input  logic                                     col_last ,
  input  logic [ldpc_enc_pkg::idx_w(pROWS)-1:0]    col_idx  ,
  input  logic [pZC-1:0]                           col_dat  ,
  input  ldpc_enc_pkg::circ_t [pROWS-1:0]          row_psi  ,  // entries (r, 0..pROWS-1)
  //
  output logic                                     row_val  ,
  output logic [pZC-1:0]                           row_dat
);

  localparam int sw = ldpc_enc_pkg::pSHIFT_W;

  ldpc_enc_pkg::circ_t psi;
  logic [pZC-1:0]      term;
  logic [pZC-1:0]      acc;

  // right cyclic rotation, bit i takes bit (i + s) mod pZC
  function automatic logic [pZC-1:0] rot_r(input logic [pZC-1:0] d, input logic [sw-1:0] s);
    logic [2*pZC-1:0] dd;
    dd = {d, d} >> s;
    return dd[pZC-1:0];
  endfunction

  assign psi  = row_psi[col_idx];                                   // circulant of this column
  assign term = psi[sw] ? '0 : rot_r(col_dat, psi[sw-1:0]);        // zero block adds nothing

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      row_val <= 1'b0;
      acc     <= '0;
    end
    else if (iclkena) begin
      row_val <= col_val & col_last;    // one cycle after last column
      if (col_val) begin
        acc <= col_last ? '0 : acc ^ term;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && col_val && col_last) begin
      row_dat <= acc ^ term;            // finished row word
    end
  end

endmodule

/* logic/ldpc_enc_row_drain.sv */
// --------------------
// lane result capture and serializer with sof/eof strobes
// --------------------
`timescale 1ns/1ps

module ldpc_enc_row_drain #(
  parameter int pZC   = ldpc_enc_pkg::pZC   ,
  parameter int pROWS = ldpc_enc_pkg::pROWS
) (
  input  logic                              iclk    ,
  input  logic                              ireset  ,
  input  logic                              iclkena ,
  //
  input  logic                              row_val ,
  input  logic [pROWS-1:0][pZC-1:0]         row_dat ,  // all lanes at once
  //
  output logic                              mm_val  ,
  output logic                              mm_sof  ,
  output logic                              mm_eof  ,
  output logic [pZC-1:0]                    mm_dat
);

  localparam int lw = $clog2(pROWS + 1);

  logic [pROWS-1:0][pZC-1:0] sreg;    // words still to send, word 0 next
  logic [lw-1:0]             left;    // remaining after current

  // --------------------
  // strobes and word counter
  // --------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      mm_val <= 1'b0;
      mm_sof <= 1'b0;
      mm_eof <= 1'b0;
      left   <= '0;
    end
    else if (iclkena) begin
      if (row_val) begin                // load, first word out at once
        mm_val <= 1'b1;
        mm_sof <= 1'b1;
        mm_eof <= (pROWS == 1);
        left   <= lw'(pROWS - 1);
      end
      else if (left != '0) begin
        mm_val <= 1'b1;
        mm_sof <= 1'b0;
        mm_eof <= (left == lw'(1));
        left   <= left - 1'b1;
      end
      else begin
        mm_val <= 1'b0;
        mm_sof <= 1'b0;
        mm_eof <= 1'b0;
      end
    end
  end

  // shift out one word per cycle
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (row_val) begin
        mm_dat <= row_dat[0];
        sreg   <= row_dat >> pZC;
      end
      else if (left != '0) begin
        mm_dat <= sreg[0];
        sreg   <= sreg >> pZC;
      end
    end
  end

endmodule

/* logic/ldpc_enc_p1.sv */
// --------------------
// first parity stage, inverse psi multiply
// feeder, row lanes, drain and output register
// --------------------
`timescale 1ns/1ps

module ldpc_enc_p1 #(
  parameter int pZC   = ldpc_enc_pkg::pZC   ,
  parameter int pROWS = ldpc_enc_pkg::pROWS
) (
  input  logic                                   iclk    ,
  input  logic                                   ireset  ,
  input  logic                                   iclkena ,
  //
  input  logic                                   bypass  ,  // identity inverse psi codes
  input  logic                                   iwrite  ,
  input  logic                                   iwstart ,
  input  logic [pZC-1:0]                         iwdat   ,
  input  ldpc_enc_pkg::circ_t [pROWS*pROWS-1:0]  inv_psi ,
  //
  output logic                                   oval    ,
  output logic                                   osof    ,
  output logic                                   oeof    ,
  output logic [pZC-1:0]                         odat
);

  localparam int iw = ldpc_enc_pkg::idx_w(pROWS);

  logic                      col_val, col_last;
  logic [iw-1:0]             col_idx;
  logic [pZC-1:0]            col_dat;
  logic [pROWS-1:0]          lane_val;
  logic [pROWS-1:0][pZC-1:0] lane_dat;
  logic                      mm_val, mm_sof, mm_eof;
  logic [pZC-1:0]            mm_dat;

  ldpc_enc_col_feed #(.pZC(pZC), .pROWS(pROWS)) feed (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .iwrite (iwrite), .iwstart (iwstart), .iwdat (iwdat),
    .col_val (col_val), .col_last (col_last), .col_idx (col_idx), .col_dat (col_dat)
  );

  // one lane per matrix row, each gets its own table row
  for (genvar r = 0; r < pROWS; r++) begin : g_row
    ldpc_enc_row_acc #(.pZC(pZC), .pROWS(pROWS)) lane (
      .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
      .col_val (col_val), .col_last (col_last), .col_idx (col_idx), .col_dat (col_dat),
      .row_psi (inv_psi[r*pROWS +: pROWS]),
      .row_val (lane_val[r]), .row_dat (lane_dat[r])
    );
  end

  ldpc_enc_row_drain #(.pZC(pZC), .pROWS(pROWS)) drain (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .row_val (&lane_val), .row_dat (lane_dat),   // lanes run in lockstep
    .mm_val (mm_val), .mm_sof (mm_sof), .mm_eof (mm_eof), .mm_dat (mm_dat)
  );

  // --------------------
  // output register
  // --------------------
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      oval <= 1'b0;
      osof <= 1'b0;
      oeof <= 1'b0;
    end
    else if (iclkena) begin
      oval <= bypass ? iwrite  : mm_val;
      osof <= bypass ? iwstart : mm_sof;
      oeof <= bypass ? 1'b0    : mm_eof;   // no eof in bypass
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      odat <= bypass ? iwdat : mm_dat;
    end
  end

endmodule

/* logic/ldpc_enc_top.sv */
// --------------------
// top level, register slave plus parity stage
// --------------------
`timescale 1ns/1ps

module ldpc_enc_top #(
  parameter int pZC   = ldpc_enc_pkg::pZC   ,
  parameter int pROWS = ldpc_enc_pkg::pROWS
) (
  input  logic                                iclk     ,
  input  logic                                ireset   ,
  input  logic                                iclkena  ,
  // wishbone slave
  input  logic                                wb_cyc   ,
  input  logic                                wb_stb   ,
  input  logic                                wb_we    ,
  input  logic [ldpc_enc_pkg::pWB_ADR_W-1:0]  wb_adr   ,
  input  logic [ldpc_enc_pkg::pWB_DAT_W-1:0]  wb_dat_w ,
  input  logic                                wb_sel   ,
  output logic [ldpc_enc_pkg::pWB_DAT_W-1:0]  wb_dat_r ,
  output logic                                wb_ack   ,
  // syndrome words in
  input  logic                                iwrite   ,
  input  logic                                iwstart  ,
  input  logic [pZC-1:0]                      iwdat    ,
  // parity words out
  output logic                                oval     ,
  output logic                                osof     ,
  output logic                                oeof     ,
  output logic [pZC-1:0]                      odat
);

  ldpc_enc_pkg::circ_t [pROWS*pROWS-1:0] inv_psi;
  logic                                  bypass;

  ldpc_enc_wb_regs #(.pROWS(pROWS)) regs (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .inv_psi (inv_psi), .bypass (bypass)
  );

  ldpc_enc_p1 #(.pZC(pZC), .pROWS(pROWS)) p1 (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .bypass (bypass), .iwrite (iwrite), .iwstart (iwstart), .iwdat (iwdat),
    .inv_psi (inv_psi),
    .oval (oval), .osof (osof), .oeof (oeof), .odat (odat)
  );

endmodule

/* verif/ldpc_enc_asserts.sv */
// --------------------
// bus and output stream rules, bound to the top level
// --------------------
`timescale 1ns/1ps

module ldpc_enc_asserts (
  input logic iclk   ,
  input logic ireset ,
  input logic wb_cyc ,
  input logic wb_stb ,
  input logic wb_ack ,
  input logic oval   ,
  input logic osof   ,
  input logic oeof
);

  // ack only answers a live request
  ack_with_req: assert property (@(posedge iclk) disable iff (ireset)
    wb_ack |-> (wb_cyc && wb_stb))
    else $error("wb_ack without wb_cyc and wb_stb");

  strobe_in_word: assert property (@(posedge iclk) disable iff (ireset)
    (osof || oeof) |-> oval)
    else $error("osof or oeof outside a valid word");

  // first clocked output after reset still quiet
  quiet_after_reset: assert property (@(posedge iclk)
    $fell(ireset) |=> !oval)
    else $error("oval high right after reset");

endmodule

bind ldpc_enc_top ldpc_enc_asserts asserts (
  .iclk (iclk), .ireset (ireset),
  .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_ack (wb_ack),
  .oval (oval), .osof (osof), .oeof (oeof)
);

/* verif/ldpc_enc_tb.sv */
// --------------------
// table driven testbench of the first parity stage
// reference model, lcg stimulus, stream collector, watchdog
// --------------------
`timescale 1ns/1ps

module ldpc_enc_tb;

  localparam int ZC    = ldpc_enc_pkg::pZC;
  localparam int ROWS  = ldpc_enc_pkg::pROWS;
  localparam int SW    = ldpc_enc_pkg::pSHIFT_W;
  localparam int CTRL  = ldpc_enc_pkg::pREG_CTRL;
  localparam int NTEST = 7;

  // one table row per test
  typedef struct packed {
    logic [1:0] mode;      // 0 identity, 1 random shifts, 2 random with zero blocks
    logic       byp;       // bypass flag
    logic       ena_rand;  // toggle iclkena
    logic [3:0] nblk;      // blocks in the test
    logic [3:0] gap;       // idle cycles after each block
  } test_row_t;

  localparam test_row_t tests [NTEST] = '{
    '{2'd0, 1'b0, 1'b0, 4'd3, 4'd3},
    '{2'd2, 1'b0, 1'b0, 4'd4, 4'd3},
    '{2'd1, 1'b0, 1'b0, 4'd3, 4'd2},
    '{2'd0, 1'b1, 1'b0, 4'd4, 4'd2},
    '{2'd2, 1'b0, 1'b0, 4'd6, 4'd1},   // minimum block spacing
    '{2'd2, 1'b0, 1'b1, 4'd5, 4'd1},
    '{2'd1, 1'b1, 1'b1, 4'd3, 4'd1}
  };

  logic                               iclk, ireset, iclkena;
  logic                               wb_cyc, wb_stb, wb_we, wb_sel, wb_ack;
  logic [ldpc_enc_pkg::pWB_ADR_W-1:0] wb_adr;
  logic [ldpc_enc_pkg::pWB_DAT_W-1:0] wb_dat_w, wb_dat_r;
  logic                               iwrite, iwstart, oval, osof, oeof;
  logic [ZC-1:0]                      iwdat, odat;

  logic [31:0]         lcg_state = 32'hff1c76d0;
  ldpc_enc_pkg::circ_t psi_tb [ROWS*ROWS];   // copy of the table in the DUT
  logic                byp_now  = 1'b0;
  logic                ena_rand = 1'b0;
  int                  err_cnt  = 0;
  int                  chk_cnt  = 0;
  logic [ZC-1:0]       exp_dat [$];
  logic                exp_sof [$];
  logic                exp_eof [$];
  int                  lat_q   [$];          // enabled cycle of each last write

  ldpc_enc_top #(.pZC(ZC), .pROWS(ROWS)) uut (
    .iclk (iclk), .ireset (ireset), .iclkena (iclkena),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
    .iwrite (iwrite), .iwstart (iwstart), .iwdat (iwdat),
    .oval (oval), .osof (osof), .oeof (oeof), .odat (odat)
  );

  initial begin
    iclk = 1'b0;
    forever #10 iclk = ~iclk;    // 20 ns period
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // bit i of the result takes bit (i + s) mod ZC
  function automatic logic [ZC-1:0] rot_right(input logic [ZC-1:0] d, input int s);
    logic [ZC-1:0] r;
    for (int i = 0; i < ZC; i++) begin
      r[i] = d[(i + s) % ZC];
    end
    return r;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // --------------------
  // wishbone master
  // --------------------
  task automatic transfer(input logic we, input int adr, input logic [7:0] dw,
                          output logic [7:0] dr);
    int n;
    @(posedge iclk);
    iclkena  <= 1'b1;
    iwrite   <= 1'b0;
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_sel   <= 1'b1;
    wb_adr   <= 5'(adr);
    wb_dat_w <= dw;
    n = 0;
    do begin
      @(negedge iclk);
      n++;
    end while (!wb_ack && n < 8);    // hold request until ack
    if (!wb_ack) begin
      $display("bus: no acknowledge for address %0d", adr);
      err_cnt++;
    end
    dr = wb_dat_r;
    @(posedge iclk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_reg(input int adr, input logic [7:0] dw);
    logic [7:0] unused;
    transfer(1'b1, adr, dw, unused);
  endtask

  task automatic read_reg(input int adr, output logic [7:0] dr);
    transfer(1'b0, adr, 8'h00, dr);
  endtask

  task automatic load_table(input int mode);
    logic [31:0]         rnd;
    ldpc_enc_pkg::circ_t e;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < ROWS; c++) begin
        rnd = lcg_next();
        case (mode)
          0:       e = (r == c) ? ldpc_enc_pkg::circ_eye : ldpc_enc_pkg::circ_zero;
          1:       e = {1'b0, rnd[SW+23:24]};
          default: e = (rnd[15:14] == 2'b00) ? ldpc_enc_pkg::circ_zero : {1'b0, rnd[SW+23:24]};
        endcase
        write_reg(r * ROWS + c, 8'(e));
        psi_tb[r * ROWS + c] = e;
      end
    end
  endtask

  // one enabled cycle, frozen cycles in between keep the inputs
  task automatic drive_cycle(input logic we, input logic st, input logic [ZC-1:0] d);
    logic [31:0] rnd;
    logic        ena;
    do begin
      @(posedge iclk);
      rnd = lcg_next();
      ena = !ena_rand || (rnd[31:30] != 2'b00);
      iclkena <= ena;
      if (ena) begin
        iwrite  <= we;
        iwstart <= st;
        iwdat   <= d;
      end
    end while (!ena);
  endtask

  // expected words from the multiply rule, then drive the block
  task automatic send_block(input int gap);
    logic [ZC-1:0]       blk [ROWS];
    logic [ZC-1:0]       acc;
    logic [31:0]         rnd;
    ldpc_enc_pkg::circ_t e;
    for (int c = 0; c < ROWS; c++) begin
      rnd = lcg_next();
      blk[c] = rnd[ZC+7:8];
    end
    for (int r = 0; r < ROWS; r++) begin
      acc = '0;
      for (int c = 0; c < ROWS; c++) begin
        e = psi_tb[r * ROWS + c];
        if (!e[SW]) begin
          acc = acc ^ rot_right(blk[c], int'(e[SW-1:0]));   // zero block adds nothing
        end
      end
      exp_dat.push_back(byp_now ? blk[r] : acc);
      exp_sof.push_back(r == 0);
      exp_eof.push_back(!byp_now && (r == ROWS - 1));       // no eof in bypass
    end
    for (int c = 0; c < ROWS; c++) begin
      drive_cycle(1'b1, (c == 0), blk[c]);
    end
    repeat (gap) drive_cycle(1'b0, 1'b0, '0);
  endtask

  // --------------------
  // collector, samples at negedge where outputs are stable
  // --------------------
  initial begin
    int en_cnt;
    int wcnt;
    int w;
    en_cnt = 0;
    wcnt   = 0;
    forever begin
      @(negedge iclk);
      if (!ireset && iclkena) begin
        en_cnt++;
        if (iwrite) begin
          wcnt = iwstart ? 1 : wcnt + 1;
          if (wcnt == ROWS && !byp_now) begin
            lat_q.push_back(en_cnt);
          end
        end
        if (oval) begin
          if (exp_dat.size() == 0) begin
            $display("output word %0h at %0t ns arrived with no block pending", odat, $time);
            err_cnt++;
          end
          else begin
            compare("output word", 32'(odat), 32'(exp_dat.pop_front()));
            compare("osof", 32'(osof), 32'(exp_sof.pop_front()));
            compare("oeof", 32'(oeof), 32'(exp_eof.pop_front()));
          end
          if (osof && !byp_now) begin
            if (lat_q.size() == 0) begin
              $display("block start at %0t ns with no complete input block", $time);
              err_cnt++;
            end
            else begin
              w = lat_q.pop_front();
              // oval launched on the enabled edge before it is seen
              compare("first word latency", 32'(en_cnt - w - 1), 32'(ROWS + 3));
            end
          end
        end
      end
    end
  end

  // watchdog, block count times block latency, slowed by iclkena, plus bus traffic
  initial begin
    int total;
    total = 0;
    for (int t = 0; t < NTEST; t++) begin
      total += int'(tests[t].nblk);
    end
    repeat (total * (ROWS + 3) * 4 + (NTEST + 1) * 300 + 500) @(posedge iclk);
    $display("watchdog: run did not finish in the expected time");
    $display("Verification failed");
    $finish;
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int         err0;
    logic [7:0] rd;
    ireset   = 1'b1;
    iclkena  = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_sel   = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    iwrite   = 1'b0;
    iwstart  = 1'b0;
    iwdat    = '0;
    repeat (16) @(posedge iclk);
    ireset <= 1'b0;

    // register map readback
    err0 = err_cnt;
    for (int i = 0; i < ROWS * ROWS; i++) begin
      read_reg(i, rd);
      // reset table, identity on the diagonal
      compare("table reset value", 32'(rd),
              32'((i / ROWS == i % ROWS) ? ldpc_enc_pkg::circ_eye : ldpc_enc_pkg::circ_zero));
    end
    read_reg(CTRL, rd);
    compare("control reset value", 32'(rd), 32'd0);
    for (int i = 0; i < ROWS * ROWS; i++) begin
      rd = 8'(lcg_next() >> 24);
      write_reg(i, rd);
      psi_tb[i] = rd[SW:0];
    end
    write_reg(CTRL, 8'hfe);
    write_reg(31, 8'hff);                  // out of map, dropped
    for (int i = 0; i < ROWS * ROWS; i++) begin
      read_reg(i, rd);
      compare("table readback", 32'(rd), 32'(psi_tb[i]));
    end
    read_reg(CTRL, rd);
    compare("control readback", 32'(rd), 32'd0);
    write_reg(CTRL, 8'h01);
    read_reg(CTRL, rd);
    compare("control readback", 32'(rd), 32'd1);
    read_reg(CTRL + 1, rd);
    compare("unmapped read", 32'(rd), 32'd0);
    read_reg(31, rd);
    compare("unmapped read", 32'(rd), 32'd0);
    $display("test 0 register map: %0d errors", err_cnt - err0);

    for (int t = 0; t < NTEST; t++) begin
      err0     = err_cnt;
      ena_rand = 1'b0;
      load_table(int'(tests[t].mode));
      write_reg(CTRL, 8'(tests[t].byp));
      byp_now  = tests[t].byp;
      ena_rand = tests[t].ena_rand;
      for (int b = 0; b < int'(tests[t].nblk); b++) begin
        send_block(int'(tests[t].gap));
      end
      while (exp_dat.size() != 0) begin
        drive_cycle(1'b0, 1'b0, '0);
      end
      repeat (12) drive_cycle(1'b0, 1'b0, '0);   // drain runs dry before table changes
      $display("test %0d mode %0d bypass %0d clkena %0d: %0d blocks, %0d errors",
               t + 1, tests[t].mode, tests[t].byp, tests[t].ena_rand, tests[t].nblk,
               err_cnt - err0);
    end

    $display("tests %0d, checks %0d, errors %0d", NTEST + 1, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Verification passed");
    end
    else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/ldpc_enc_pkg.sv
logic/ldpc_enc_wb_regs.sv
logic/ldpc_enc_col_feed.sv
logic/ldpc_enc_row_acc.sv
logic/ldpc_enc_row_drain.sv
logic/ldpc_enc_p1.sv
logic/ldpc_enc_top.sv
verif/ldpc_enc_asserts.sv
verif/ldpc_enc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ldpc_enc_tb -f tb.f -o ldpc_enc_sim

./obj_dir/ldpc_enc_sim | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation reported no failure"
